/* axi_order_geom_pkg.sv */
`default_nettype none

// address and cache block geometry shared by the design and the testbench
package axi_order_geom_pkg;

  // byte address width of the cache side requests
  localparam int ADDR_WIDTH_DEF = 32;

  // low address bits inside one block of 8 words of 4 bytes
  localparam int BLOCK_OFFSET_WIDTH_DEF = 5;

  // block tag width is the address width less the offset bits
  localparam int TAG_WIDTH_DEF = ADDR_WIDTH_DEF - BLOCK_OFFSET_WIDTH_DEF;

endpackage

`default_nettype wire

/* axi_order_chan_pkg.sv */
`default_nettype none

// channel description for the ordering guard
package axi_order_chan_pkg;

  // selects the completion rule of a slot allocator
  typedef enum logic {
    CHAN_READ  = 1'b0,
    CHAN_WRITE = 1'b1
  } chan_e;

  // outstanding requests tracked per channel
  localparam int NUM_SLOTS_DEF = 4;

endpackage

`default_nettype wire

/* axi_order_slot_alloc.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_order_slot_alloc #(
  parameter int                        NUM_SLOTS = axi_order_chan_pkg::NUM_SLOTS_DEF,
  parameter axi_order_chan_pkg::chan_e CHAN      = axi_order_chan_pkg::CHAN_WRITE
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 accept_valid_i,
  input  logic                 accept_ready_i,
  input  logic                 done_valid_i,
  input  logic                 done_ready_i,
  input  logic                 done_last_i,
  output logic                 set_v_o,
  output logic                 clr_v_o,
  output logic [NUM_SLOTS-1:0] slot_sel_o
);

  logic                 done_last;
  logic                 done_v;
  logic [NUM_SLOTS-1:0] set_ptr;
  logic [NUM_SLOTS-1:0] clr_ptr;

  assign set_v_o = accept_valid_i & accept_ready_i;

  // reads complete on the last beat, writes on the single B response
  assign done_last = (CHAN == axi_order_chan_pkg::CHAN_READ) ? done_last_i : 1'b1;
  assign done_v    = done_valid_i & done_ready_i & done_last;

  // completion takes effect in the cycle after the handshake
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      clr_v_o <= 1'b0;
    end else begin
      clr_v_o <= done_v;
    end
  end

  generate
    if (NUM_SLOTS == 1) begin : g_single
      assign set_ptr = 1'b1;
      assign clr_ptr = 1'b1;
    end else begin : g_rotate
      logic [NUM_SLOTS-1:0] set_ptr_q;
      logic [NUM_SLOTS-1:0] clr_ptr_q;

      // both pointers start at slot 0 and rotate upward
      always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
          set_ptr_q <= {{(NUM_SLOTS-1){1'b0}}, 1'b1};
          clr_ptr_q <= {{(NUM_SLOTS-1){1'b0}}, 1'b1};
        end else begin
          if (set_v_o) begin
            set_ptr_q <= {set_ptr_q[NUM_SLOTS-2:0], set_ptr_q[NUM_SLOTS-1]};
          end
          if (clr_v_o) begin
            clr_ptr_q <= {clr_ptr_q[NUM_SLOTS-2:0], clr_ptr_q[NUM_SLOTS-1]};
          end
        end
      end

      assign set_ptr = set_ptr_q;
      assign clr_ptr = clr_ptr_q;
    end
  endgenerate

  // clear owns the table write port when both happen
  assign slot_sel_o = clr_v_o ? clr_ptr : set_ptr;

endmodule

`default_nettype wire

/* axi_order_tag_cam.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_order_tag_cam #(
  parameter int ADDR_WIDTH         = axi_order_geom_pkg::ADDR_WIDTH_DEF,
  parameter int BLOCK_OFFSET_WIDTH = axi_order_geom_pkg::BLOCK_OFFSET_WIDTH_DEF,
  parameter int NUM_SLOTS          = axi_order_chan_pkg::NUM_SLOTS_DEF,
  localparam int TAG_WIDTH         = ADDR_WIDTH - BLOCK_OFFSET_WIDTH
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 set_v_i,
  input  logic                 clr_v_i,
  input  logic [NUM_SLOTS-1:0] slot_sel_i,
  input  logic [TAG_WIDTH-1:0] set_tag_i,
  input  logic                 look_v_i,
  input  logic [TAG_WIDTH-1:0] look_tag_i,
  output logic [NUM_SLOTS-1:0] empty_o,
  output logic [NUM_SLOTS-1:0] match_o
);

  logic [NUM_SLOTS-1:0] valid_q;
  logic [TAG_WIDTH-1:0] tag_q [NUM_SLOTS];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else begin
      for (int i = 0; i < NUM_SLOTS; i++) begin
        if (slot_sel_i[i]) begin
          if (clr_v_i) begin
            valid_q[i] <= 1'b0;
          end else if (set_v_i) begin
            valid_q[i] <= 1'b1;
          end
        end
      end
    end
  end

  // tags are written with the valid bit and left in place by a clear
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NUM_SLOTS; i++) begin
      if (slot_sel_i[i] && set_v_i && !clr_v_i) begin
        tag_q[i] <= set_tag_i;
      end
    end
  end

  assign empty_o = ~valid_q;

  always_comb begin
    for (int i = 0; i < NUM_SLOTS; i++) begin
      match_o[i] = look_v_i & valid_q[i] & (tag_q[i] == look_tag_i);
    end
  end

endmodule

`default_nettype wire

/* axi_order_hazard_check.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_order_hazard_check #(
  parameter int NUM_SLOTS = axi_order_chan_pkg::NUM_SLOTS_DEF
) (
  input  logic                 r_v_i,
  input  logic                 w_v_i,
  input  logic [NUM_SLOTS-1:0] wr_match_i,
  input  logic [NUM_SLOTS-1:0] rd_match_i,
  input  logic [NUM_SLOTS-1:0] wr_empty_i,
  input  logic [NUM_SLOTS-1:0] rd_empty_i,
  input  logic                 wr_clr_v_i,
  input  logic                 rd_clr_v_i,
  output logic                 r_fence_o,
  output logic                 w_fence_o
);

  logic rd_full;
  logic wr_full;
  logic r_hazard;
  logic w_hazard;

  assign rd_full = ~|rd_empty_i;
  assign wr_full = ~|wr_empty_i;

  // a read waits behind a write to the same block, and the reverse
  assign r_hazard = |wr_match_i;
  assign w_hazard = |rd_match_i;

  // own table full or freeing a slot also holds the request
  assign r_fence_o = r_v_i & (r_hazard | rd_full | rd_clr_v_i);
  assign w_fence_o = w_v_i & (w_hazard | wr_full | wr_clr_v_i);

endmodule

`default_nettype wire

/* axi_order_top.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_order_top #(
  parameter int ADDR_WIDTH         = axi_order_geom_pkg::ADDR_WIDTH_DEF,
  parameter int BLOCK_OFFSET_WIDTH = axi_order_geom_pkg::BLOCK_OFFSET_WIDTH_DEF,
  parameter int NUM_SLOTS          = axi_order_chan_pkg::NUM_SLOTS_DEF,
  localparam int TAG_WIDTH         = ADDR_WIDTH - BLOCK_OFFSET_WIDTH
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  r_v_i,
  input  logic [ADDR_WIDTH-1:0] r_addr_i,
  input  logic                  w_v_i,
  input  logic [ADDR_WIDTH-1:0] w_addr_i,
  input  logic                  axi_awvalid_i,
  input  logic                  axi_awready_i,
  input  logic                  axi_bvalid_i,
  input  logic                  axi_bready_i,
  input  logic                  axi_arvalid_i,
  input  logic                  axi_arready_i,
  input  logic                  axi_rvalid_i,
  input  logic                  axi_rready_i,
  input  logic                  axi_rlast_i,
  output logic                  r_fence_o,
  output logic                  w_fence_o
);

  // the same block tag slice feeds the set and look ports
  wire [TAG_WIDTH-1:0] r_tag = r_addr_i[ADDR_WIDTH-1:BLOCK_OFFSET_WIDTH];
  wire [TAG_WIDTH-1:0] w_tag = w_addr_i[ADDR_WIDTH-1:BLOCK_OFFSET_WIDTH];

  logic                 wr_set_v;
  logic                 wr_clr_v;
  logic [NUM_SLOTS-1:0] wr_slot_sel;
  logic [NUM_SLOTS-1:0] wr_empty;
  logic [NUM_SLOTS-1:0] wr_match;

  logic                 rd_set_v;
  logic                 rd_clr_v;
  logic [NUM_SLOTS-1:0] rd_slot_sel;
  logic [NUM_SLOTS-1:0] rd_empty;
  logic [NUM_SLOTS-1:0] rd_match;

  // write channel tracked from AW accept to B accept
  axi_order_slot_alloc #(
    .NUM_SLOTS (NUM_SLOTS),
    .CHAN      (axi_order_chan_pkg::CHAN_WRITE)
  ) u_wr_slots (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .accept_valid_i (axi_awvalid_i),
    .accept_ready_i (axi_awready_i),
    .done_valid_i   (axi_bvalid_i),
    .done_ready_i   (axi_bready_i),
    .done_last_i    (1'b1),
    .set_v_o        (wr_set_v),
    .clr_v_o        (wr_clr_v),
    .slot_sel_o     (wr_slot_sel)
  );

  // looked up by the read request
  axi_order_tag_cam #(
    .ADDR_WIDTH         (ADDR_WIDTH),
    .BLOCK_OFFSET_WIDTH (BLOCK_OFFSET_WIDTH),
    .NUM_SLOTS          (NUM_SLOTS)
  ) u_wr_cam (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .set_v_i    (wr_set_v),
    .clr_v_i    (wr_clr_v),
    .slot_sel_i (wr_slot_sel),
    .set_tag_i  (w_tag),
    .look_v_i   (r_v_i),
    .look_tag_i (r_tag),
    .empty_o    (wr_empty),
    .match_o    (wr_match)
  );

  // read channel tracked from AR accept to last R accept
  axi_order_slot_alloc #(
    .NUM_SLOTS (NUM_SLOTS),
    .CHAN      (axi_order_chan_pkg::CHAN_READ)
  ) u_rd_slots (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .accept_valid_i (axi_arvalid_i),
    .accept_ready_i (axi_arready_i),
    .done_valid_i   (axi_rvalid_i),
    .done_ready_i   (axi_rready_i),
    .done_last_i    (axi_rlast_i),
    .set_v_o        (rd_set_v),
    .clr_v_o        (rd_clr_v),
    .slot_sel_o     (rd_slot_sel)
  );

  // looked up by the write request
  axi_order_tag_cam #(
    .ADDR_WIDTH         (ADDR_WIDTH),
    .BLOCK_OFFSET_WIDTH (BLOCK_OFFSET_WIDTH),
    .NUM_SLOTS          (NUM_SLOTS)
  ) u_rd_cam (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .set_v_i    (rd_set_v),
    .clr_v_i    (rd_clr_v),
    .slot_sel_i (rd_slot_sel),
    .set_tag_i  (r_tag),
    .look_v_i   (w_v_i),
    .look_tag_i (w_tag),
    .empty_o    (rd_empty),
    .match_o    (rd_match)
  );

  axi_order_hazard_check #(
    .NUM_SLOTS (NUM_SLOTS)
  ) u_hazard (
    .r_v_i      (r_v_i),
    .w_v_i      (w_v_i),
    .wr_match_i (wr_match),
    .rd_match_i (rd_match),
    .wr_empty_i (wr_empty),
    .rd_empty_i (rd_empty),
    .wr_clr_v_i (wr_clr_v),
    .rd_clr_v_i (rd_clr_v),
    .r_fence_o  (r_fence_o),
    .w_fence_o  (w_fence_o)
  );

endmodule

`default_nettype wire

/* axi_order_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_order_checker #(
  parameter int ADDR_WIDTH         = axi_order_geom_pkg::ADDR_WIDTH_DEF,
  parameter int BLOCK_OFFSET_WIDTH = axi_order_geom_pkg::BLOCK_OFFSET_WIDTH_DEF,
  parameter int NUM_SLOTS          = axi_order_chan_pkg::NUM_SLOTS_DEF
) (
  input  wire logic                  clk_i, rst_n_i, r_v_i, w_v_i,
  input  wire logic [ADDR_WIDTH-1:0] r_addr_i, w_addr_i,
  input  wire logic axi_awvalid_i, axi_awready_i, axi_bvalid_i, axi_bready_i,
  input  wire logic axi_arvalid_i, axi_arready_i, axi_rvalid_i, axi_rready_i, axi_rlast_i,
  input  wire logic r_fence_o, w_fence_o,
  input  wire logic exp_valid_i, exp_r_fence_i, exp_w_fence_i,
  output int        error_count_o,
  output int        check_count_o
);

  logic [NUM_SLOTS-1:0]    wr_valid, rd_valid;
  logic [ADDR_WIDTH-1:0]   wr_addr [NUM_SLOTS];
  logic [ADDR_WIDTH-1:0]   rd_addr [NUM_SLOTS];
  int                      wr_set, wr_clr, rd_set, rd_clr;
  logic                    wr_clr_pend, rd_clr_pend, wr_hit, rd_hit, exp_r, exp_w;

  function automatic logic same_block(input logic [ADDR_WIDTH-1:0] a, b);
    return (a >> BLOCK_OFFSET_WIDTH) == (b >> BLOCK_OFFSET_WIDTH);
  endfunction

  task automatic compare_bit(input string name, input logic exp, input logic got);
    check_count_o++;
    if (exp !== got) begin
      error_count_o++;
      $display("[FAIL] %s expected 0x%0h got 0x%0h at %0t", name, exp, got, $time);
    end
  endtask

  // outstanding blocks per channel where a clear wins over a set in the same cycle
  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      {wr_valid, rd_valid, wr_clr_pend, rd_clr_pend} = '0;
      {wr_set, wr_clr, rd_set, rd_clr} = '0;
    end else begin
      if (wr_clr_pend) begin
        wr_valid[wr_clr] = 1'b0;
        wr_clr = (wr_clr + 1) % NUM_SLOTS;
      end
      if (axi_awvalid_i && axi_awready_i) begin
        if (!wr_clr_pend) {wr_valid[wr_set], wr_addr[wr_set]} = {1'b1, w_addr_i};
        wr_set = (wr_set + 1) % NUM_SLOTS;
      end
      wr_clr_pend = axi_bvalid_i && axi_bready_i;
      if (rd_clr_pend) begin
        rd_valid[rd_clr] = 1'b0;
        rd_clr = (rd_clr + 1) % NUM_SLOTS;
      end
      if (axi_arvalid_i && axi_arready_i) begin
        if (!rd_clr_pend) {rd_valid[rd_set], rd_addr[rd_set]} = {1'b1, r_addr_i};
        rd_set = (rd_set + 1) % NUM_SLOTS;
      end
      rd_clr_pend = axi_rvalid_i && axi_rready_i && axi_rlast_i;
    end
  end

  initial {error_count_o, check_count_o} = '0;

  always @(negedge clk_i) begin
    if (rst_n_i) begin
      {wr_hit, rd_hit} = 2'b00;
      for (int i = 0; i < NUM_SLOTS; i++) begin
        if (wr_valid[i] && same_block(wr_addr[i], r_addr_i)) wr_hit = 1'b1;
        if (rd_valid[i] && same_block(rd_addr[i], w_addr_i)) rd_hit = 1'b1;
      end
      exp_r = r_v_i && (wr_hit || (&rd_valid) || rd_clr_pend);
      exp_w = w_v_i && (rd_hit || (&wr_valid) || wr_clr_pend);
      compare_bit("r_fence_o", exp_r, r_fence_o);
      compare_bit("w_fence_o", exp_w, w_fence_o);
      if (exp_valid_i) begin
        compare_bit("r_fence_o (table)", exp_r_fence_i, r_fence_o);
        compare_bit("w_fence_o (table)", exp_w_fence_i, w_fence_o);
      end
    end
  end

endmodule

`default_nettype wire

/* axi_order_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_order_sva (
  input wire logic clk_i,
  input wire logic rst_n_i,
  input wire logic r_v_i,
  input wire logic w_v_i,
  input wire logic axi_awvalid_i,
  input wire logic axi_awready_i,
  input wire logic axi_bvalid_i,
  input wire logic axi_bready_i,
  input wire logic axi_arvalid_i,
  input wire logic axi_arready_i,
  input wire logic axi_rvalid_i,
  input wire logic axi_rready_i,
  input wire logic axi_rlast_i,
  input wire logic r_fence_o,
  input wire logic w_fence_o
);

  logic aw_acc;
  logic b_acc;
  logic ar_acc;
  logic r_acc;
  logic busy_q;

  assign aw_acc = axi_awvalid_i & axi_awready_i;
  assign b_acc  = axi_bvalid_i & axi_bready_i;
  assign ar_acc = axi_arvalid_i & axi_arready_i;
  assign r_acc  = axi_rvalid_i & axi_rready_i & axi_rlast_i;

  // set by the first accept or completion after reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
    end else if (aw_acc || b_acc || ar_acc || r_acc) begin
      busy_q <= 1'b1;
    end
  end

  // tables are empty while in reset
  assert property (@(posedge clk_i) !rst_n_i |-> !r_fence_o && !w_fence_o)
    else $error("fence high during reset");

  // a fence needs its request and something tracked since reset
  assert property (@(posedge clk_i) disable iff (!rst_n_i) r_fence_o |-> r_v_i && busy_q)
    else $error("read fence without read request or tracked transaction");
  assert property (@(posedge clk_i) disable iff (!rst_n_i) w_fence_o |-> w_v_i && busy_q)
    else $error("write fence without write request or tracked transaction");

  // the cycle after a completion handshake is the clearing cycle
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
                   r_v_i && $past(r_acc) |-> r_fence_o)
    else $error("read fence low in clearing cycle");
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
                   w_v_i && $past(b_acc) |-> w_fence_o)
    else $error("write fence low in clearing cycle");

endmodule

bind axi_order_top axi_order_sva u_sva (
  .clk_i(clk_i), .rst_n_i(rst_n_i), .r_v_i(r_v_i), .w_v_i(w_v_i),
  .axi_awvalid_i(axi_awvalid_i), .axi_awready_i(axi_awready_i),
  .axi_bvalid_i(axi_bvalid_i), .axi_bready_i(axi_bready_i),
  .axi_arvalid_i(axi_arvalid_i), .axi_arready_i(axi_arready_i),
  .axi_rvalid_i(axi_rvalid_i), .axi_rready_i(axi_rready_i), .axi_rlast_i(axi_rlast_i),
  .r_fence_o(r_fence_o), .w_fence_o(w_fence_o)
);

`default_nettype wire

/* axi_order_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_order_tb;

  localparam int ADDR_WIDTH = axi_order_geom_pkg::ADDR_WIDTH_DEF;
  localparam int BOW        = axi_order_geom_pkg::BLOCK_OFFSET_WIDTH_DEF;
  localparam int NUM_SLOTS  = axi_order_chan_pkg::NUM_SLOTS_DEF;
  localparam int NUM_ROWS   = 32;
  localparam int NUM_RAND   = 200;
  localparam int TIMEOUT    = 2000;

  logic clk_i, rst_n_i, r_v_i, w_v_i, r_fence_o, w_fence_o;
  logic [ADDR_WIDTH-1:0] r_addr_i, w_addr_i;
  logic axi_awvalid_i, axi_awready_i, axi_bvalid_i, axi_bready_i;
  logic axi_arvalid_i, axi_arready_i, axi_rvalid_i, axi_rready_i, axi_rlast_i;
  logic exp_valid, exp_r_fence, exp_w_fence, stim_done;
  int   error_count, check_count, n_rows, cycles, seed;

  // row bits are r_v, w_v, aw, b, ar, r, rlast and the expected r and w fences
  logic [8:0]            row_ctl   [NUM_ROWS];
  logic [ADDR_WIDTH-1:0] row_raddr [NUM_ROWS];
  logic [ADDR_WIDTH-1:0] row_waddr [NUM_ROWS];

  axi_order_top #(
    .ADDR_WIDTH         (ADDR_WIDTH),
    .BLOCK_OFFSET_WIDTH (BOW),
    .NUM_SLOTS          (NUM_SLOTS)
  ) dut_i (.*);

  axi_order_checker #(.ADDR_WIDTH(ADDR_WIDTH), .BLOCK_OFFSET_WIDTH(BOW), .NUM_SLOTS(NUM_SLOTS))
    u_checker (.*, .exp_valid_i(exp_valid), .exp_r_fence_i(exp_r_fence),
               .exp_w_fence_i(exp_w_fence), .error_count_o(error_count),
               .check_count_o(check_count));

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic put_row(input logic rv, input logic [ADDR_WIDTH-1:0] ra, input logic wv,
                         input logic [ADDR_WIDTH-1:0] wa, input logic [4:0] axi_ev,
                         input logic erf, input logic ewf);
    row_ctl[n_rows]   = {rv, wv, axi_ev, erf, ewf};
    row_raddr[n_rows] = ra;
    row_waddr[n_rows] = wa;
    n_rows++;
  endtask

  task automatic drive(input logic rv, input logic [ADDR_WIDTH-1:0] ra, input logic wv,
                       input logic [ADDR_WIDTH-1:0] wa, input logic [8:0] ev);
    r_v_i = rv;
    r_addr_i = ra;
    w_v_i = wv;
    w_addr_i = wa;
    {axi_awvalid_i, axi_awready_i, axi_bvalid_i, axi_bready_i} = ev[8:5];
    {axi_arvalid_i, axi_arready_i, axi_rvalid_i, axi_rready_i, axi_rlast_i} = ev[4:0];
  endtask

  // directed sequence where axi_ev bits are aw, b, ar, r, rlast as accepted handshakes
  task automatic build_table();
    n_rows = 0;
    put_row(1, 32'h1000, 1, 32'h2040, 5'b00000, 0, 0);
    put_row(1, 32'h2040, 1, 32'h1000, 5'b00000, 0, 0);
    put_row(0, 32'h0,    1, 32'h1000, 5'b10000, 0, 0);
    put_row(1, 32'h1004, 0, 32'h0,    5'b00000, 1, 0);
    put_row(1, 32'h2040, 0, 32'h0,    5'b00000, 0, 0);
    put_row(1, 32'h2040, 1, 32'h1000, 5'b00000, 0, 0);
    put_row(1, 32'h1000, 0, 32'h0,    5'b01000, 1, 0);
    // write clearing cycle
    put_row(1, 32'h1000, 1, 32'h2040, 5'b00000, 1, 1);
    put_row(1, 32'h1000, 0, 32'h0,    5'b00000, 0, 0);
    put_row(1, 32'h1000, 0, 32'h0,    5'b00100, 0, 0);
    put_row(0, 32'h0,    1, 32'h1000, 5'b00000, 0, 1);
    put_row(0, 32'h0,    1, 32'h2040, 5'b00000, 0, 0);
    put_row(0, 32'h0,    1, 32'h1000, 5'b00010, 0, 1);
    put_row(1, 32'h2040, 1, 32'h1000, 5'b00000, 0, 1);
    put_row(0, 32'h0,    1, 32'h1000, 5'b00011, 0, 1);
    put_row(1, 32'h2040, 1, 32'h1000, 5'b00000, 1, 1);
    put_row(1, 32'h2040, 1, 32'h1000, 5'b00000, 0, 0);
    // fill the read table
    put_row(1, 32'h3000, 0, 32'h0,    5'b00100, 0, 0);
    put_row(1, 32'h3020, 0, 32'h0,    5'b00100, 0, 0);
    put_row(1, 32'h3040, 0, 32'h0,    5'b00100, 0, 0);
    put_row(1, 32'h3060, 0, 32'h0,    5'b00100, 0, 0);
    put_row(1, 32'h2040, 1, 32'h3000, 5'b00000, 1, 1);
    put_row(1, 32'h2040, 0, 32'h0,    5'b00011, 1, 0);
    put_row(1, 32'h2040, 0, 32'h0,    5'b00000, 1, 0);
    put_row(1, 32'h2040, 0, 32'h0,    5'b00000, 0, 0);
    put_row(0, 32'h0,    0, 32'h0,    5'b00011, 0, 0);
    put_row(0, 32'h0,    0, 32'h0,    5'b00000, 0, 0);
    put_row(0, 32'h0,    0, 32'h0,    5'b00011, 0, 0);
    put_row(0, 32'h0,    0, 32'h0,    5'b00000, 0, 0);
    put_row(0, 32'h0,    0, 32'h0,    5'b00011, 0, 0);
    put_row(0, 32'h0,    1, 32'h3060, 5'b00000, 0, 1);
    put_row(0, 32'h0,    1, 32'h3060, 5'b00000, 0, 0);
  endtask

  function automatic logic [ADDR_WIDTH-1:0] rand_addr();
    return 32'h4000 + (($random(seed) & 3) << BOW) + ($random(seed) & 28);
  endfunction

  initial begin
    seed = 30;
    stim_done = 1'b0;
    exp_valid = 1'b0;
    {exp_r_fence, exp_w_fence} = 2'b00;
    rst_n_i = 1'b0;
    drive(0, '0, 0, '0, '0);
    build_table();
    @(posedge clk_i);
    // requests during reset while both tables are held empty
    #1 drive(1, 32'h1000, 1, 32'h1000, '0);
    repeat (7) @(posedge clk_i);
    #1 rst_n_i = 1'b1;
    for (int i = 0; i < NUM_ROWS; i++) begin
      @(posedge clk_i);
      #1;
      drive(row_ctl[i][8], row_raddr[i], row_ctl[i][7], row_waddr[i],
            {{2{row_ctl[i][6]}}, {2{row_ctl[i][5]}}, {2{row_ctl[i][4]}},
             {2{row_ctl[i][3]}}, row_ctl[i][2]});
      exp_valid = 1'b1;
      {exp_r_fence, exp_w_fence} = row_ctl[i][1:0];
    end
    for (int i = 0; i < NUM_RAND; i++) begin
      @(posedge clk_i);
      #1;
      exp_valid = 1'b0;
      drive(1'($random(seed)), rand_addr(), 1'($random(seed)), rand_addr(),
            9'($random(seed)));
    end
    @(posedge clk_i);
    #1 drive(0, '0, 0, '0, '0);
    stim_done = 1'b1;
  end

  initial begin
    cycles = 0;
    while (!stim_done && cycles < TIMEOUT) begin
      @(posedge clk_i);
      cycles++;
    end
    if (!stim_done) $display("timeout: stimulus did not finish in %0d cycles", TIMEOUT);
    @(posedge clk_i);
    $display("checks %0d, errors %0d", check_count, error_count);
    if (stim_done && error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* axi_order.f */
axi_order_geom_pkg.sv
axi_order_chan_pkg.sv
axi_order_slot_alloc.sv
axi_order_tag_cam.sv
axi_order_hazard_check.sv
axi_order_top.sv
axi_order_checker.sv
axi_order_sva.sv
axi_order_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --assert --timing -j 0
TOP       ?= axi_order_tb
FILELIST  ?= axi_order.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Test OK"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
